//--- common/bru_config.svh
`ifndef BRU_CONFIG_SVH
`define BRU_CONFIG_SVH

// Address and data width of the core
`define BRU_XLEN 32

// Direction counters in the branch history table
// Must be a power of two
`define BHT_ENTRIES 64

// Entries in the direct-mapped branch target buffer
// Must be a power of two
`define BTB_ENTRIES 16

// Stall cycles following the flush pulse
// At least one, the refill counter counts down to one
`define REFILL_CYCLES 2

`endif

//--- common/bru_pkg.sv
`include "bru_config.svh"

package bru_pkg;

    // Control-flow class as seen by the predictor
    // NoCF also means no table write on resolution
    typedef enum logic [1:0] {
        NoCF   = 2'd0,
        Branch = 2'd1,
        JumpR  = 2'd2
    } cf_t;

    // Prediction for the pc being resolved
    typedef struct packed {
        // Class from the BTB, NoCF on a miss
        cf_t                  cf;
        // High bit of the direction counter
        logic                 taken;
        // Target stored in the BTB entry
        logic [`BRU_XLEN-1:0] predict_address;
    } predict_t;

    // Outcome of one control-flow instruction
    typedef struct packed {
        logic [`BRU_XLEN-1:0] pc;
        // Corrected next pc, used as redirect address on a mispredict
        logic [`BRU_XLEN-1:0] target_address;
        logic                 is_taken;
        logic                 is_mispredict;
        // Class written back to BHT and BTB
        cf_t                  cf_type;
    } resolved_t;

endpackage

//--- common/resolve_if.sv
interface resolve_if (
    input logic clk_i
);

    // Qualifies the resolution below
    logic               valid;
    // Target, direction and mispredict flag of the instruction
    bru_pkg::resolved_t resolved;

    // Branch unit produces the resolution
    // Clock only serves the protocol checks there
    modport unit (
        input  clk_i,
        output valid,
        output resolved
    );

    // Redirect control accepts and sequences
    modport ctrl (
        input valid,
        input resolved
    );

    // Predictor tables take the write data, enable comes from commit
    modport tbl (
        input resolved
    );

endinterface

//--- src/branch_unit.sv
`include "bru_config.svh"

module branch_unit (
    resolve_if.unit              res,
    input logic                  jal_i,
    input logic                  jalr_i,
    input logic                  branch_i,
    input logic                  valid_i,
    input logic                  alu_res_i,
    input logic                  is_rv16_i,
    input logic [`BRU_XLEN-1:0]  pc_i,
    input logic [`BRU_XLEN-1:0]  rs1_data_i,
    input logic [`BRU_XLEN-1:0]  imm_i,
    input bru_pkg::predict_t     predict_i
);

    // Instruction sizes for the fall-through address
    localparam logic [`BRU_XLEN-1:0] STEP_RVC = 'd2;
    localparam logic [`BRU_XLEN-1:0] STEP_RVI = 'd4;

    logic [`BRU_XLEN-1:0] next_pc;
    logic [`BRU_XLEN-1:0] jump_base;
    logic [`BRU_XLEN-1:0] target_address;
    logic                 pred_taken;
    logic                 jalr_miss;

    // Sequential successor of this instruction
    assign next_pc = pc_i + (is_rv16_i ? STEP_RVC : STEP_RVI);

    // JALR jumps relative to rs1, everything else relative to pc
    assign jump_base = jalr_i ? rs1_data_i : pc_i;

    always_comb begin
        target_address = jump_base + imm_i;
        // JALR drops the lowest target bit
        if (jalr_i) begin
            target_address[0] = 1'b0;
        end
    end

    // Taken prediction only counts for a pc known as a branch
    assign pred_taken = (predict_i.cf == bru_pkg::Branch) && predict_i.taken;

    // Register jump is wrong when never seen or its target moved
    assign jalr_miss = (predict_i.cf == bru_pkg::NoCF) ||
                       (target_address != predict_i.predict_address);

    always_comb begin
        res.resolved.pc             = pc_i;
        res.resolved.target_address = target_address;
        res.resolved.is_taken       = 1'b0;
        res.resolved.is_mispredict  = 1'b0;
        res.resolved.cf_type        = bru_pkg::NoCF;
        if (valid_i) begin
            if (branch_i) begin
                // Not taken falls through to the next instruction
                res.resolved.target_address = alu_res_i ? target_address : next_pc;
                res.resolved.is_taken       = alu_res_i;
                res.resolved.is_mispredict  = alu_res_i != pred_taken;
                // Always trains the direction counter
                res.resolved.cf_type        = bru_pkg::Branch;
            end else if (jalr_i) begin
                res.resolved.is_taken      = 1'b1;
                res.resolved.is_mispredict = jalr_miss;
                // BTB only rewritten when the stored target was wrong
                res.resolved.cf_type       = jalr_miss ? bru_pkg::JumpR : bru_pkg::NoCF;
            end else if (jal_i) begin
                // Target already taken in decode
                res.resolved.is_taken = 1'b1;
            end
        end
    end

    // Valid passes straight to the controller
    assign res.valid = valid_i;

    // Decode hands over at most one control-flow class per instruction
    a_one_class: assert property (
        @(posedge res.clk_i) valid_i |-> $onehot0({jal_i, jalr_i, branch_i})
    );

endmodule

//--- predictor/bht.sv
`include "bru_config.svh"

module bht (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 commit_i,
    resolve_if.tbl               res,
    input  logic [`BRU_XLEN-1:0] lookup_pc_i,
    output logic                 taken_o
);

    localparam int IDX_W = $clog2(`BHT_ENTRIES);

    // Counter reset value, weakly not taken
    localparam logic [1:0] CTR_INIT = 2'b01;
    localparam logic [1:0] CTR_MAX  = 2'b11;
    localparam logic [1:0] CTR_MIN  = 2'b00;

    // Packed so the whole table can be compared across cycles
    logic [`BHT_ENTRIES-1:0][1:0] ctr_q;

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;
    logic [1:0]       wr_old;
    logic [1:0]       wr_new;

    // Halfword bit skipped, compressed neighbours share a counter
    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign wr_idx = res.resolved.pc[IDX_W+1:2];

    // Upper counter half predicts taken
    assign taken_o = ctr_q[rd_idx][1];

    // Only conditional branches train direction
    assign wr_en  = commit_i && (res.resolved.cf_type == bru_pkg::Branch);
    assign wr_old = ctr_q[wr_idx];

    // Saturating step in the direction of the outcome
    always_comb begin
        wr_new = wr_old;
        if (res.resolved.is_taken) begin
            if (wr_old != CTR_MAX) begin
                wr_new = wr_old + 2'd1;
            end
        end else begin
            if (wr_old != CTR_MIN) begin
                wr_new = wr_old - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int i = 0; i < `BHT_ENTRIES; i++) begin
                ctr_q[i] <= CTR_INIT;
            end
        end else if (wr_en) begin
            ctr_q[wr_idx] <= wr_new;
        end
    end

    // Table only moves on an accepted instruction
    a_write_on_commit: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !commit_i |=> $stable(ctr_q)
    );

endmodule

//--- predictor/btb.sv
`include "bru_config.svh"

module btb (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 commit_i,
    resolve_if.tbl               res,
    input  logic [`BRU_XLEN-1:0] lookup_pc_i,
    output logic                 hit_o,
    output bru_pkg::cf_t         cf_o,
    output logic [`BRU_XLEN-1:0] target_o
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `BRU_XLEN - IDX_W - 2;

    // Only the valid bits are cleared
    logic [`BTB_ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]        tag_q    [`BTB_ENTRIES];
    bru_pkg::cf_t            cf_q     [`BTB_ENTRIES];
    logic [`BRU_XLEN-1:0]    target_q [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_en;

    // Index above the halfword bit, tag is the rest of the pc
    assign rd_idx = lookup_pc_i[IDX_W+1:2];
    assign rd_tag = lookup_pc_i[`BRU_XLEN-1:IDX_W+2];
    assign wr_idx = res.resolved.pc[IDX_W+1:2];
    assign wr_tag = res.resolved.pc[`BRU_XLEN-1:IDX_W+2];

    assign hit_o    = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign cf_o     = cf_q[rd_idx];
    assign target_o = target_q[rd_idx];

    // Register jumps that missed, and taken branches
    assign wr_en = commit_i &&
                   ((res.resolved.cf_type == bru_pkg::JumpR) ||
                    ((res.resolved.cf_type == bru_pkg::Branch) && res.resolved.is_taken));

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tag_q[wr_idx]    <= wr_tag;
            cf_q[wr_idx]     <= res.resolved.cf_type;
            target_q[wr_idx] <= res.resolved.target_address;
        end
    end

endmodule

//--- src/redirect_ctrl.sv
`include "bru_config.svh"

module redirect_ctrl (
    input  logic                 clk_i,
    input  logic                 reset_i,
    resolve_if.ctrl              res,
    output logic                 commit_o,
    output logic                 ready_o,
    output logic                 flush_o,
    output logic [`BRU_XLEN-1:0] redirect_pc_o,
    output logic [15:0]          mispredict_count_o
);

    localparam int CNT_W = $clog2(`REFILL_CYCLES + 1);

    typedef enum logic [1:0] {
        IDLE,
        FLUSH,
        REFILL
    } state_e;

    state_e               state_q;
    state_e               state_d;
    logic [CNT_W-1:0]     refill_q;
    logic [CNT_W-1:0]     refill_d;
    logic [`BRU_XLEN-1:0] redirect_pc_q;
    logic [15:0]          count_q;
    logic                 start_flush;

    // Instructions accepted only while idle
    assign ready_o  = (state_q == IDLE);
    assign commit_o = res.valid && ready_o;
    assign flush_o  = (state_q == FLUSH);

    assign start_flush = commit_o && res.resolved.is_mispredict;

    always_comb begin
        state_d  = state_q;
        refill_d = refill_q;
        case (state_q)
            IDLE: begin
                if (start_flush) begin
                    state_d = FLUSH;
                end
            end
            FLUSH: begin
                // Single flush cycle, then the fixed refill wait
                state_d  = REFILL;
                refill_d = CNT_W'(`REFILL_CYCLES);
            end
            REFILL: begin
                if (refill_q == CNT_W'(1)) begin
                    state_d = IDLE;
                end
                refill_d = refill_q - CNT_W'(1);
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q       <= IDLE;
            refill_q      <= '0;
            redirect_pc_q <= '0;
            count_q       <= '0;
        end else begin
            state_q  <= state_d;
            refill_q <= refill_d;
            // Corrected pc held until the next mispredict
            if (start_flush) begin
                redirect_pc_q <= res.resolved.target_address;
            end
            if (flush_o) begin
                count_q <= count_q + 16'd1;
            end
        end
    end

    assign redirect_pc_o      = redirect_pc_q;
    assign mispredict_count_o = count_q;

    // Flush lasts exactly one cycle
    a_flush_single: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_o |=> !flush_o
    );

    // No acceptance from the flush through the end of refill
    a_no_commit_refill: assert property (
        @(posedge clk_i) disable iff (reset_i)
        flush_o |-> !commit_o [*(`REFILL_CYCLES + 1)]
    );

endmodule

//--- src/branch_resolve_top.sv
`include "bru_config.svh"

module branch_resolve_top (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 valid_i,
    input  logic                 jal_i,
    input  logic                 jalr_i,
    input  logic                 branch_i,
    input  logic                 alu_res_i,
    input  logic                 is_rv16_i,
    input  logic [`BRU_XLEN-1:0] pc_i,
    input  logic [`BRU_XLEN-1:0] rs1_data_i,
    input  logic [`BRU_XLEN-1:0] imm_i,
    output logic                 ready_o,
    output logic                 flush_o,
    output logic [`BRU_XLEN-1:0] redirect_pc_o,
    output logic [15:0]          mispredict_count_o
);

    resolve_if res_if (
        .clk_i(clk_i)
    );

    logic                 commit;
    logic                 bht_taken;
    logic                 btb_hit;
    bru_pkg::cf_t         btb_cf;
    logic [`BRU_XLEN-1:0] btb_target;
    bru_pkg::predict_t    predict;

    // Tables looked up at the pc under resolution
    bht u_bht (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .commit_i    (commit),
        .res         (res_if.tbl),
        .lookup_pc_i (pc_i),
        .taken_o     (bht_taken)
    );

    btb u_btb (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .commit_i    (commit),
        .res         (res_if.tbl),
        .lookup_pc_i (pc_i),
        .hit_o       (btb_hit),
        .cf_o        (btb_cf),
        .target_o    (btb_target)
    );

    // BTB miss means the pc is not yet known as control flow
    assign predict.cf              = btb_hit ? btb_cf : bru_pkg::NoCF;
    assign predict.taken           = bht_taken;
    assign predict.predict_address = btb_target;

    branch_unit u_branch_unit (
        .res        (res_if.unit),
        .jal_i      (jal_i),
        .jalr_i     (jalr_i),
        .branch_i   (branch_i),
        .valid_i    (valid_i),
        .alu_res_i  (alu_res_i),
        .is_rv16_i  (is_rv16_i),
        .pc_i       (pc_i),
        .rs1_data_i (rs1_data_i),
        .imm_i      (imm_i),
        .predict_i  (predict)
    );

    redirect_ctrl u_redirect_ctrl (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .res                (res_if.ctrl),
        .commit_o           (commit),
        .ready_o            (ready_o),
        .flush_o            (flush_o),
        .redirect_pc_o      (redirect_pc_o),
        .mispredict_count_o (mispredict_count_o)
    );

endmodule

//--- testbench/tb_branch_resolve.sv
`include "bru_config.svh"

module tb_branch_resolve;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int K_BRANCH = 0;
    localparam int K_JALR = 1;
    localparam int K_JAL = 2;
    localparam int WAIT_LIMIT = 20;
    localparam int RANDOM_COUNT = 300;
    localparam int BHT_IDX = $clog2(`BHT_ENTRIES);
    localparam int BTB_IDX = $clog2(`BTB_ENTRIES);
    localparam int TAG_W = `BRU_XLEN - BTB_IDX - 2;

    logic clk_i;
    logic reset_i;
    logic valid_i;
    logic jal_i;
    logic jalr_i;
    logic branch_i;
    logic alu_res_i;
    logic is_rv16_i;
    logic [`BRU_XLEN-1:0] pc_i;
    logic [`BRU_XLEN-1:0] rs1_data_i;
    logic [`BRU_XLEN-1:0] imm_i;
    logic ready_o;
    logic flush_o;
    logic [`BRU_XLEN-1:0] redirect_pc_o;
    logic [15:0] mispredict_count_o;

    // Reference predictor state, same reset contents as the tables
    logic [1:0] bht_m [`BHT_ENTRIES];
    logic btb_valid_m [`BTB_ENTRIES];
    logic [TAG_W-1:0] btb_tag_m [`BTB_ENTRIES];
    bru_pkg::cf_t btb_cf_m [`BTB_ENTRIES];
    logic [`BRU_XLEN-1:0] btb_target_m [`BTB_ENTRIES];

    // Expectation for the instruction on the inputs
    logic exp_misp;
    logic [`BRU_XLEN-1:0] exp_target;
    // Same expectation one cycle later, next to the flush
    logic acc_q;
    logic acc_misp_q;
    logic [`BRU_XLEN-1:0] acc_target_q;
    logic end_check;
    logic [31:0] lcg_state;
    int model_count;
    int value_errors;
    int other_errors;
    string test_name;

    branch_resolve_top dut0 (
        .clk_i              (clk_i),
        .reset_i            (reset_i),
        .valid_i            (valid_i),
        .jal_i              (jal_i),
        .jalr_i             (jalr_i),
        .branch_i           (branch_i),
        .alu_res_i          (alu_res_i),
        .is_rv16_i          (is_rv16_i),
        .pc_i               (pc_i),
        .rs1_data_i         (rs1_data_i),
        .imm_i              (imm_i),
        .ready_o            (ready_o),
        .flush_o            (flush_o),
        .redirect_pc_o      (redirect_pc_o),
        .mispredict_count_o (mispredict_count_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        if (reset_i) begin
            acc_q <= 1'b0;
            acc_misp_q <= 1'b0;
            acc_target_q <= '0;
        end else begin
            acc_q <= valid_i && ready_o;
            acc_misp_q <= exp_misp;
            acc_target_q <= exp_target;
        end
    end

    task automatic report_value(input string check, input logic [31:0] expected,
                                input logic [31:0] actual);
        value_errors++;
        $display("** Error %s (%s): expected %h, actual %h", test_name, check, expected, actual);
    endtask

    task automatic report_failure(input string what);
        other_errors++;
        $display("Failure in %s: %s", test_name, what);
    endtask

    // First cycle out of reset
    a_reset_ready: assert property (@(posedge clk_i) $fell(reset_i) |-> ready_o)
        else report_failure("ready_o low right after reset");
    a_reset_flush: assert property (@(posedge clk_i) $fell(reset_i) |-> !flush_o)
        else report_failure("flush_o high right after reset");
    a_reset_count: assert property (@(posedge clk_i) $fell(reset_i) |-> mispredict_count_o == 0)
        else report_value("reset count", 32'd0, 32'($sampled(mispredict_count_o)));

    // Flush follows exactly the accepted mispredicts
    a_flush_match: assert property (@(posedge clk_i) disable iff (reset_i)
        acc_q |-> flush_o == acc_misp_q)
        else report_value("flush", 32'($sampled(acc_misp_q)), 32'($sampled(flush_o)));
    a_flush_cause: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_o |-> acc_q && acc_misp_q)
        else report_failure("flush_o raised without an accepted mispredict");
    a_redirect_pc: assert property (@(posedge clk_i) disable iff (reset_i)
        acc_q && acc_misp_q |-> redirect_pc_o == acc_target_q)
        else report_value("redirect pc", $sampled(acc_target_q), $sampled(redirect_pc_o));

    // Stall of one flush cycle plus the refill, then ready again
    a_refill_stall: assert property (@(posedge clk_i) disable iff (reset_i)
        flush_o |-> !ready_o [*(`REFILL_CYCLES + 1)] ##1 ready_o)
        else report_failure("ready_o stall after flush has the wrong length");
    a_ready_kept: assert property (@(posedge clk_i) disable iff (reset_i)
        acc_q && !acc_misp_q |-> ready_o)
        else report_failure("ready_o dropped after a correctly predicted instruction");

    a_final_count: assert property (@(posedge clk_i) end_check |->
        mispredict_count_o == 16'(model_count))
        else report_value("final count", 32'(model_count), 32'($sampled(mispredict_count_o)));

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic wait_ready();
        int waited;
        waited = 0;
        while (!ready_o && waited < WAIT_LIMIT) begin
            @(negedge clk_i);
            waited++;
        end
    endtask

    task automatic write_btb(input logic [`BRU_XLEN-1:0] pc, input bru_pkg::cf_t cf,
                             input logic [`BRU_XLEN-1:0] target);
        logic [BTB_IDX-1:0] tidx;
        tidx = pc[BTB_IDX+1:2];
        btb_valid_m[tidx] = 1'b1;
        btb_tag_m[tidx] = pc[`BRU_XLEN-1:BTB_IDX+2];
        btb_cf_m[tidx] = cf;
        btb_target_m[tidx] = target;
    endtask

    // Drives one instruction on a falling edge and trains the model after acceptance
    task automatic issue(input int kind, input logic [31:0] pc, input logic [31:0] rs1,
                         input logic [31:0] imm, input logic taken, input logic rv16);
        logic [31:0] fall;
        logic [31:0] tgt;
        logic [BHT_IDX-1:0] bidx;
        logic [BTB_IDX-1:0] tidx;
        bru_pkg::cf_t pcf;
        logic miss;
        wait_ready();
        if (!ready_o) begin
            report_failure("ready_o stayed low, instruction could not be issued");
        end else begin
            fall = pc + (rv16 ? 32'd2 : 32'd4);
            tgt = (kind == K_JALR) ? ((rs1 + imm) & ~32'd1) : (pc + imm);
            bidx = pc[BHT_IDX+1:2];
            tidx = pc[BTB_IDX+1:2];
            // BTB miss leaves the pc unclassified
            pcf = bru_pkg::NoCF;
            if (btb_valid_m[tidx] && btb_tag_m[tidx] == pc[`BRU_XLEN-1:BTB_IDX+2]) begin
                pcf = btb_cf_m[tidx];
            end
            miss = 1'b0;
            exp_target = tgt;
            if (kind == K_BRANCH) begin
                miss = taken != ((pcf == bru_pkg::Branch) && bht_m[bidx][1]);
                exp_target = taken ? tgt : fall;
            end else if (kind == K_JALR) begin
                miss = (pcf == bru_pkg::NoCF) || (tgt != btb_target_m[tidx]);
            end
            exp_misp = miss;
            if (miss) begin
                model_count++;
            end
            valid_i = 1'b1;
            branch_i = (kind == K_BRANCH);
            jalr_i = (kind == K_JALR);
            jal_i = (kind == K_JAL);
            alu_res_i = taken;
            is_rv16_i = rv16;
            pc_i = pc;
            rs1_data_i = rs1;
            imm_i = imm;
            @(negedge clk_i);
            valid_i = 1'b0;
            branch_i = 1'b0;
            jalr_i = 1'b0;
            jal_i = 1'b0;
            // Counter saturates at both ends
            if (kind == K_BRANCH) begin
                if (taken && bht_m[bidx] != 2'd3) begin
                    bht_m[bidx] = bht_m[bidx] + 2'd1;
                end else if (!taken && bht_m[bidx] != 2'd0) begin
                    bht_m[bidx] = bht_m[bidx] - 2'd1;
                end
                if (taken) begin
                    write_btb(pc, bru_pkg::Branch, tgt);
                end
            end else if (kind == K_JALR && miss) begin
                write_btb(pc, bru_pkg::JumpR, tgt);
            end
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] pc;
        logic [31:0] imm;
        int kind;
        clk_i = 1'b0;
        reset_i = 1'b1;
        valid_i = 1'b0;
        jal_i = 1'b0;
        jalr_i = 1'b0;
        branch_i = 1'b0;
        alu_res_i = 1'b0;
        is_rv16_i = 1'b0;
        pc_i = '0;
        rs1_data_i = '0;
        imm_i = '0;
        exp_misp = 1'b0;
        exp_target = '0;
        end_check = 1'b0;
        lcg_state = 32'd97;
        model_count = 0;
        value_errors = 0;
        other_errors = 0;
        test_name = "reset";
        for (int i = 0; i < `BHT_ENTRIES; i++) begin
            bht_m[i] = 2'd1;
        end
        for (int i = 0; i < `BTB_ENTRIES; i++) begin
            btb_valid_m[i] = 1'b0;
            btb_tag_m[i] = '0;
            btb_cf_m[i] = bru_pkg::NoCF;
            btb_target_m[i] = '0;
        end
        repeat (4) @(negedge clk_i);
        reset_i = 1'b0;
        @(negedge clk_i);

        test_name = "mispredict";
        issue(K_BRANCH, 32'h100, 32'h0, 32'h40, 1'b1, 1'b0);

        // Counter climbs past one, then a not-taken outcome flushes
        test_name = "direction";
        repeat (3) issue(K_BRANCH, 32'h100, 32'h0, 32'h40, 1'b1, 1'b0);
        issue(K_BRANCH, 32'h100, 32'h0, 32'h40, 1'b0, 1'b0);
        repeat (3) issue(K_BRANCH, 32'h242, 32'h0, 32'h1c, 1'b1, 1'b1);
        issue(K_BRANCH, 32'h242, 32'h0, 32'h1c, 1'b0, 1'b1);

        // Odd immediate gives a target with bit 0 to clear
        test_name = "jalr";
        issue(K_JALR, 32'h300, 32'h1000, 32'h21, 1'b1, 1'b0);
        issue(K_JALR, 32'h300, 32'h1000, 32'h21, 1'b1, 1'b0);
        issue(K_JALR, 32'h300, 32'h2000, 32'h21, 1'b1, 1'b0);

        test_name = "jal";
        repeat (4) issue(K_JAL, 32'h400, 32'h0, 32'h80, 1'b1, 1'b0);
        issue(K_JAL, 32'h100, 32'h0, 32'h10, 1'b1, 1'b0);

        // Small pc pool so that entries get reused and alias
        test_name = "random";
        for (int n = 0; n < RANDOM_COUNT; n++) begin
            r = lcg_next();
            r2 = lcg_next();
            kind = int'(r[31:28]) % 3;
            pc = 32'h1000 + {r[26:21], 2'b00} + (r[20] ? 32'h4000 : 32'h0);
            pc = pc + (r2[26] ? 32'd2 : 32'd0);
            imm = {22'd0, r[19:11], 1'b0};
            if (kind == K_JALR) begin
                imm = {28'd0, r2[29:28], 2'b00} + {31'd0, r2[30]};
            end
            issue(kind, pc, 32'h8000 + {26'd0, r[9:8], 4'h0}, imm, r2[31], r2[26]);
        end

        test_name = "final count";
        wait_ready();
        if (!ready_o) begin
            report_failure("ready_o stayed low at the end of the run");
        end
        end_check = 1'b1;
        @(negedge clk_i);
        end_check = 1'b0;
        @(negedge clk_i);

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+common
common/bru_pkg.sv
common/resolve_if.sv
src/branch_unit.sv
predictor/bht.sv
predictor/btb.sv
src/redirect_ctrl.sv
src/branch_resolve_top.sv
testbench/tb_branch_resolve.sv

//--- Bender.yml
package:
  name: branch_resolve

export_include_dirs:
  - common

sources:
  # Package and interface first, then the leaf blocks and the top
  - include_dirs:
      - common
    files:
      - common/bru_pkg.sv
      - common/resolve_if.sv
      - src/branch_unit.sv
      - predictor/bht.sv
      - predictor/btb.sv
      - src/redirect_ctrl.sv
      - src/branch_resolve_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - testbench/tb_branch_resolve.sv
